// ==== Bender.yml ====
package:
  name: rob

sources:
  - include_dirs:
      - hw
    files:
      - hw/rob_pkg.sv
      - hw/rob_ctrl.sv
      - hw/rob_entry_file.sv
      - hw/rename_reg_file.sv
      - hw/branch_history_table.sv
      - hw/rob_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/rob_tb.sv

// ==== dv/rob_cases.txt ====
# op fields in hex: alloc rd br st pt pc ft | ex tag res tgt tk | ls tag res
# commit tag rd val redir rpc | tagchk tag full | srcchk rs tag rdy data chkval val
# predchk pc taken | idle n | rdylow n | test name | done
test in_order
idle 2
tagchk 1 0
alloc 1 0 0 0 10 14
alloc 2 0 0 0 14 18
alloc 3 0 0 0 18 1c
ex 3 333 0 0
ex 2 222 0 0
ex 1 111 0 0
commit 1 1 111 0 0
commit 2 2 222 0 0
commit 3 3 333 0 0
done
test operand_lookup
alloc 6 0 0 0 20 24
ex 4 600 0 0
srcchk 6 4 1 600 0 0
commit 4 6 600 0 0
srcchk 6 0 0 0 1 600
alloc 7 0 0 0 24 28
alloc 7 0 0 0 28 2c
ex 5 701 0 0
commit 5 7 701 0 0
srcchk 7 6 0 0 0 0
ls 6 702
commit 6 7 702 0 0
srcchk 7 0 0 0 1 702
done
test store
alloc 0 0 1 0 2c 30
commit 7 0 0 0 0
done
test mispredict
alloc 0 1 0 0 100 104
alloc 5 0 0 0 104 108
srcchk 5 1 0 0 0 0
ex 8 0 200 1
commit 8 0 0 1 200
tagchk 1 0
srcchk 5 0 0 0 0 0
alloc 0 1 0 1 100 104
ex 1 0 200 1
commit 1 0 0 0 0
done
test predictor
predchk 48 0
alloc 0 1 0 1 48 4c
alloc 0 1 0 1 48 4c
ex 2 0 80 1
ex 3 0 80 1
commit 2 0 0 0 0
commit 3 0 0 0 0
predchk 48 1
predchk 4c 0
predchk 44 0
done
test full_and_stall
alloc 8 0 0 0 60 64
alloc 9 0 0 0 64 68
alloc a 0 0 0 68 6c
alloc b 0 0 0 6c 70
alloc c 0 0 0 70 74
tagchk 1 0
alloc d 0 0 0 74 78
tagchk 2 1
ex 4 55 0 0
rdylow 4
commit 4 8 55 0 0
done

// ==== dv/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_tb;

    logic                clk;
    logic                arst_n;
    logic                rdy;
    logic                alloc_valid;
    rob_pkg::reg_idx_t   alloc_rd;
    logic                alloc_is_branch;
    logic                alloc_is_store;
    logic                alloc_pred_taken;
    rob_pkg::word_t      alloc_pc;
    rob_pkg::word_t      alloc_fallthrough_pc;
    rob_pkg::rob_tag_t   alloc_tag;
    logic                full;
    logic                ex_valid;
    rob_pkg::rob_tag_t   ex_tag;
    rob_pkg::word_t      ex_result;
    rob_pkg::word_t      ex_target;
    logic                ex_taken;
    logic                ls_valid;
    rob_pkg::rob_tag_t   ls_tag;
    rob_pkg::word_t      ls_result;
    logic                commit_valid;
    rob_pkg::reg_idx_t   commit_rd;
    rob_pkg::rob_tag_t   commit_tag;
    rob_pkg::word_t      commit_value;
    logic                redirect_valid;
    rob_pkg::word_t      redirect_pc;
    rob_pkg::reg_idx_t   rs1;
    rob_pkg::reg_idx_t   rs2;
    rob_pkg::rob_tag_t   src1_tag;
    rob_pkg::rob_tag_t   src2_tag;
    logic                src1_ready;
    logic                src2_ready;
    rob_pkg::word_t      src1_data;
    rob_pkg::word_t      src2_data;
    rob_pkg::word_t      src1_value;
    rob_pkg::word_t      src2_value;
    rob_pkg::word_t      pred_pc;
    logic                pred_taken;

    integer          seed = 32'h2acd_30e8;
    integer          fd;
    integer          code;
    integer          errors;
    integer          test_errors;
    integer          tests_run;
    integer          tests_failed;
    integer          tail_m;
    reg [8*16-1:0]   op;
    reg [8*32-1:0]   tname;
    reg [8*256-1:0]  line;
    logic [31:0]     a, b, c, d, e, f;
    // slots that may hold an entry after the dispatched cases
    logic [`ROB_DEPTH-1:0] live;

    rob_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report(input string msg);
        $display("[FAIL] %0t ns %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    // one cycle with all strobes low
    task automatic next_cycle();
        @(posedge clk);
        alloc_valid <= 1'b0;
        ex_valid    <= 1'b0;
        ls_valid    <= 1'b0;
        rdy         <= 1'b1;
    endtask

    // filler cycle with an execution strobe aimed at a free slot
    task automatic filler_cycle();
        integer start;
        integer k;
        integer slot;
        next_cycle();
        start = $random(seed);
        slot  = -1;
        for (k = 0; k < `ROB_DEPTH; k++) begin
            if (slot < 0 && !live[(start + k) & (`ROB_DEPTH - 1)]) begin
                slot = (start + k) & (`ROB_DEPTH - 1);
            end
        end
        if (slot >= 0) begin
            ex_valid <= 1'b1;
            ex_tag   <= slot[3:0] + 4'd1;
        end
    endtask

    task automatic wait_commit(input logic [31:0] tag, rd, val, redir, rpc);
        integer n;
        logic   seen;
        seen = 1'b0;
        for (n = 0; n < 50 && !seen; n++) begin
            filler_cycle();
            #1;
            seen = commit_valid;
        end
        if (!seen) begin
            $display("timeout: no commit seen within 50 cycles for tag %0d", tag);
            errors++;
            test_errors++;
        end else begin
            // a redirect empties the whole buffer
            if (redir[0]) begin
                live   = '0;
                tail_m = 0;
            end else begin
                live[(tag - 1) % `ROB_DEPTH] = 1'b0;
            end
            assert (commit_tag == tag[3:0] && commit_rd == rd[4:0])
                else report($sformatf("commit tag/rd %0d/%0d, expected %0d/%0d",
                                      commit_tag, commit_rd, tag, rd));
            assert (commit_value == val)
                else report($sformatf("commit_value %h, expected %h", commit_value, val));
            assert (redirect_valid == redir[0])
                else report($sformatf("redirect_valid %b, expected %b",
                                      redirect_valid, redir[0]));
            // redirect_pc only means something with the pulse
            if (redir[0]) begin
                assert (redirect_pc == rpc)
                    else report($sformatf("redirect_pc %h, expected %h", redirect_pc, rpc));
            end
        end
    endtask

    initial begin
        errors               = 0;
        test_errors          = 0;
        tests_run            = 0;
        tests_failed         = 0;
        tail_m               = 0;
        live                 = '0;
        arst_n               = 1'b0;
        rdy                  = 1'b1;
        alloc_valid          = 1'b0;
        alloc_rd             = '0;
        alloc_is_branch      = 1'b0;
        alloc_is_store       = 1'b0;
        alloc_pred_taken     = 1'b0;
        alloc_pc             = '0;
        alloc_fallthrough_pc = '0;
        ex_valid             = 1'b0;
        ex_tag               = '0;
        ex_result            = '0;
        ex_target            = '0;
        ex_taken             = 1'b0;
        ls_valid             = 1'b0;
        ls_tag               = '0;
        ls_result            = '0;
        rs1                  = '0;
        rs2                  = '0;
        pred_pc              = '0;
        tname                = "none";
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("dv/rob_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file dv/rob_cases.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = '0;
            code = $fgets(line, fd);
            op = '0;
            code = $sscanf(line, "%s %h %h %h %h %h %h", op, a, b, c, d, e, f);
            if (op == "test") begin
                code = $sscanf(line, "%s %s", op, tname);
                test_errors = 0;
            end else if (op == "done") begin
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %0s: %0s (%0d errors)", tname,
                         (test_errors == 0) ? "ok" : "FAILED", test_errors);
            end else if (op == "alloc") begin
                next_cycle();
                alloc_valid          <= 1'b1;
                alloc_rd             <= a[4:0];
                alloc_is_branch      <= b[0];
                alloc_is_store       <= c[0];
                alloc_pred_taken     <= d[0];
                alloc_pc             <= e;
                alloc_fallthrough_pc <= f;
                live[tail_m] = 1'b1;
                tail_m       = (tail_m + 1) % `ROB_DEPTH;
            end else if (op == "ex") begin
                next_cycle();
                ex_valid  <= 1'b1;
                ex_tag    <= a[3:0];
                ex_result <= b;
                ex_target <= c;
                ex_taken  <= d[0];
            end else if (op == "ls") begin
                next_cycle();
                ls_valid  <= 1'b1;
                ls_tag    <= a[3:0];
                ls_result <= b;
            end else if (op == "idle") begin
                repeat (a) filler_cycle();
            end else if (op == "rdylow") begin
                repeat (a) begin
                    next_cycle();
                    rdy <= 1'b0;
                    #1;
                    assert (!commit_valid) else report("commit_valid high during stall");
                end
            end else if (op == "commit") begin
                wait_commit(a, b, c, d, e);
            end else if (op == "tagchk") begin
                next_cycle();
                #1;
                assert (alloc_tag == a[3:0] && full == b[0])
                    else report($sformatf("alloc_tag/full %0d/%b, expected %0d/%b",
                                          alloc_tag, full, a, b[0]));
            end else if (op == "srcchk") begin
                next_cycle();
                rs1 <= a[4:0];
                rs2 <= a[4:0];
                #1;
                assert (src1_tag == b[3:0] && src2_tag == b[3:0])
                    else report($sformatf("src tag %0d, expected %0d", src1_tag, b));
                assert (src1_ready == c[0] && src2_ready == c[0])
                    else report($sformatf("src ready %b, expected %b", src1_ready, c[0]));
                if (c[0] || b == 0) begin
                    assert (src1_data == d && src2_data == d)
                        else report($sformatf("src data %h, expected %h", src1_data, d));
                end
                if (e[0]) begin
                    assert (src1_value == f && src2_value == f)
                        else report($sformatf("src value %h, expected %h", src1_value, f));
                end
            end else if (op == "predchk") begin
                next_cycle();
                pred_pc <= a;
                #1;
                assert (pred_taken == b[0])
                    else report($sformatf("pred_taken %b at pc %h, expected %b",
                                          pred_taken, a, b[0]));
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hw/branch_history_table.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module branch_history_table (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             bht_update,
    input  rob_pkg::word_t   bht_pc,
    input  logic             bht_taken,
    input  rob_pkg::word_t   pred_pc,
    output logic             pred_taken
);

    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    logic [1:0]       counters [`BHT_ENTRIES];
    logic [IDX_W-1:0] upd_idx;
    logic [IDX_W-1:0] pred_idx;

    // word aligned pc, skip the low two bits
    assign upd_idx  = bht_pc[IDX_W+1:2];
    assign pred_idx = pred_pc[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // weakly not taken
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (bht_update) begin
            if (bht_taken && (counters[upd_idx] != 2'b11)) begin
                counters[upd_idx] <= counters[upd_idx] + 1'b1;
            end else if (!bht_taken && (counters[upd_idx] != 2'b00)) begin
                counters[upd_idx] <= counters[upd_idx] - 1'b1;
            end
        end
    end

    assign pred_taken = counters[pred_idx][1];

endmodule

// ==== hw/rename_reg_file.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rename_reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rdy,
    input  logic                flush,
    input  logic                alloc_en,
    input  rob_pkg::reg_idx_t   alloc_rd,
    input  rob_pkg::rob_tag_t   alloc_tag,
    input  logic                commit_valid,
    input  rob_pkg::reg_idx_t   commit_rd,
    input  rob_pkg::rob_tag_t   commit_tag,
    input  rob_pkg::word_t      commit_value,
    input  rob_pkg::reg_idx_t   rs1,
    input  rob_pkg::reg_idx_t   rs2,
    output rob_pkg::rob_tag_t   src1_tag,
    output rob_pkg::rob_tag_t   src2_tag,
    output rob_pkg::word_t      src1_value,
    output rob_pkg::word_t      src2_value
);

    rob_pkg::word_t    regs [`NUM_REGS];
    rob_pkg::rob_tag_t tags [`NUM_REGS];
    logic              commit_hit;

    // only the newest producer of a register may retire its tag
    assign commit_hit = commit_valid && (commit_rd != '0) && (tags[commit_rd] == commit_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                tags[i] <= '0;
            end
        end else if (rdy) begin
            if (flush) begin
                for (int i = 0; i < `NUM_REGS; i++) begin
                    tags[i] <= '0;
                end
            end else if (commit_hit) begin
                tags[commit_rd] <= '0;
            end
            // x0 is never renamed
            if (alloc_en && (alloc_rd != '0)) begin
                tags[alloc_rd] <= alloc_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && commit_hit) begin
            regs[commit_rd] <= commit_value;
        end
    end

    assign src1_tag   = tags[rs1];
    assign src2_tag   = tags[rs2];
    assign src1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign src2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/rob_ctrl.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rdy,
    input  logic                alloc_valid,
    input  logic                head_busy,
    input  logic                head_ready,
    input  logic                head_is_store,
    input  logic                head_is_branch,
    input  logic                head_mispredict,
    input  rob_pkg::word_t      head_redirect_pc,
    input  rob_pkg::reg_idx_t   head_rd,
    input  rob_pkg::word_t      head_value,
    input  rob_pkg::word_t      head_pc,
    input  logic                head_taken,
    output logic                alloc_en,
    output rob_pkg::rob_idx_t   tail_idx,
    output rob_pkg::rob_tag_t   alloc_tag,
    output logic                retire_en,
    output rob_pkg::rob_idx_t   head_idx,
    output logic                flush,
    output logic                full,
    output logic                commit_valid,
    output rob_pkg::reg_idx_t   commit_rd,
    output rob_pkg::rob_tag_t   commit_tag,
    output rob_pkg::word_t      commit_value,
    output logic                redirect_valid,
    output rob_pkg::word_t      redirect_pc,
    output logic                bht_update,
    output rob_pkg::word_t      bht_pc,
    output logic                bht_taken
);

    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;
    localparam rob_pkg::rob_idx_t LAST_IDX = rob_pkg::rob_idx_t'(`ROB_DEPTH - 1);

    rob_pkg::rob_idx_t head_q;
    rob_pkg::rob_idx_t tail_q;
    rob_pkg::rob_idx_t head_next;
    rob_pkg::rob_idx_t tail_next;
    logic [CNT_W-1:0]  count_q;
    logic              head_done;
    logic              bht_update_q;

    assign head_next = (head_q == LAST_IDX) ? '0 : head_q + 1'b1;
    assign tail_next = (tail_q == LAST_IDX) ? '0 : tail_q + 1'b1;

    // stores never get a writeback, they only need to be at the head
    assign head_done = head_busy && (head_ready || head_is_store);

    // the registered redirect is the flush cycle, nothing new enters or leaves
    assign flush     = redirect_valid;
    assign alloc_en  = rdy && alloc_valid && !flush;
    assign retire_en = rdy && head_done && !flush;

    assign tail_idx  = tail_q;
    assign head_idx  = head_q;
    assign alloc_tag = {1'b0, tail_q} + 1'b1;
    assign full      = count_q >= CNT_W'(`ROB_DEPTH - `ROB_FULL_MARGIN);

    // predictor sees the update once, even if a stall holds the pulse
    assign bht_update = bht_update_q && rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            bht_update_q   <= 1'b0;
        end else if (rdy) begin
            if (flush) begin
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
            end else begin
                if (alloc_en) begin
                    tail_q <= tail_next;
                end
                if (retire_en) begin
                    head_q <= head_next;
                end
                count_q <= count_q + CNT_W'(alloc_en) - CNT_W'(retire_en);
            end
            commit_valid   <= retire_en;
            redirect_valid <= retire_en && head_mispredict;
            bht_update_q   <= retire_en && head_is_branch;
        end
    end

    // commit fields, qualified by the pulses above
    always_ff @(posedge clk) begin
        if (retire_en) begin
            commit_rd    <= head_rd;
            commit_tag   <= {1'b0, head_q} + 1'b1;
            commit_value <= head_value;
            redirect_pc  <= head_redirect_pc;
            bht_pc       <= head_pc;
            bht_taken    <= head_taken;
        end
    end

endmodule

// ==== hw/rob_entry_file.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_entry_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rdy,
    input  logic                flush,
    input  logic                alloc_en,
    input  rob_pkg::rob_idx_t   tail_idx,
    input  rob_pkg::reg_idx_t   alloc_rd,
    input  logic                alloc_is_branch,
    input  logic                alloc_is_store,
    input  logic                alloc_pred_taken,
    input  rob_pkg::word_t      alloc_pc,
    input  rob_pkg::word_t      alloc_fallthrough_pc,
    input  logic                ex_valid,
    input  rob_pkg::rob_tag_t   ex_tag,
    input  rob_pkg::word_t      ex_result,
    input  rob_pkg::word_t      ex_target,
    input  logic                ex_taken,
    input  logic                ls_valid,
    input  rob_pkg::rob_tag_t   ls_tag,
    input  rob_pkg::word_t      ls_result,
    input  logic                retire_en,
    input  rob_pkg::rob_idx_t   head_idx,
    input  rob_pkg::rob_tag_t   src1_tag,
    input  rob_pkg::rob_tag_t   src2_tag,
    output logic                src1_ready,
    output logic                src2_ready,
    output rob_pkg::word_t      src1_data,
    output rob_pkg::word_t      src2_data,
    output logic                head_busy,
    output logic                head_ready,
    output logic                head_is_store,
    output logic                head_is_branch,
    output logic                head_mispredict,
    output rob_pkg::word_t      head_redirect_pc,
    output rob_pkg::reg_idx_t   head_rd,
    output rob_pkg::word_t      head_value,
    output rob_pkg::word_t      head_pc,
    output logic                head_taken
);

    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] ready;
    logic [`ROB_DEPTH-1:0] is_branch;
    logic [`ROB_DEPTH-1:0] is_store;
    logic [`ROB_DEPTH-1:0] pred_taken;
    logic [`ROB_DEPTH-1:0] taken;
    rob_pkg::word_t        pc          [`ROB_DEPTH];
    rob_pkg::word_t        fallthrough [`ROB_DEPTH];
    rob_pkg::word_t        target      [`ROB_DEPTH];
    rob_pkg::word_t        data        [`ROB_DEPTH];
    rob_pkg::reg_idx_t     rd          [`ROB_DEPTH];

    rob_pkg::rob_idx_t     ex_idx;
    rob_pkg::rob_idx_t     ls_idx;
    rob_pkg::rob_idx_t     src1_idx;
    rob_pkg::rob_idx_t     src2_idx;
    logic                  ex_hit;
    logic                  ls_hit;

    // tag to slot
    assign ex_idx   = rob_pkg::rob_idx_t'(ex_tag - 1'b1);
    assign ls_idx   = rob_pkg::rob_idx_t'(ls_tag - 1'b1);
    assign src1_idx = rob_pkg::rob_idx_t'(src1_tag - 1'b1);
    assign src2_idx = rob_pkg::rob_idx_t'(src2_tag - 1'b1);

    // strobes to idle slots are dropped
    assign ex_hit = ex_valid && (ex_tag != '0) && busy[ex_idx];
    assign ls_hit = ls_valid && (ls_tag != '0) && busy[ls_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= '0;
            ready <= '0;
        end else if (rdy) begin
            if (flush) begin
                busy  <= '0;
                ready <= '0;
            end else begin
                // ready stays set after retire so lookups still forward
                // until the rename file has taken the value
                if (retire_en) begin
                    busy[head_idx] <= 1'b0;
                end
                if (ex_hit) begin
                    ready[ex_idx] <= 1'b1;
                end
                if (ls_hit) begin
                    ready[ls_idx] <= 1'b1;
                end
                if (alloc_en) begin
                    busy[tail_idx]  <= 1'b1;
                    ready[tail_idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (ex_hit) begin
                data[ex_idx]   <= ex_result;
                target[ex_idx] <= ex_target;
                taken[ex_idx]  <= ex_taken;
            end
            if (ls_hit) begin
                data[ls_idx] <= ls_result;
            end
            if (alloc_en) begin
                is_branch[tail_idx]   <= alloc_is_branch;
                is_store[tail_idx]    <= alloc_is_store;
                pred_taken[tail_idx]  <= alloc_pred_taken;
                pc[tail_idx]          <= alloc_pc;
                fallthrough[tail_idx] <= alloc_fallthrough_pc;
                rd[tail_idx]          <= alloc_rd;
                // stores commit this zero
                data[tail_idx]        <= '0;
                taken[tail_idx]       <= 1'b0;
            end
        end
    end

    // operand lookup
    assign src1_ready = (src1_tag != '0) && ready[src1_idx];
    assign src2_ready = (src2_tag != '0) && ready[src2_idx];
    assign src1_data  = (src1_tag != '0) ? data[src1_idx] : '0;
    assign src2_data  = (src2_tag != '0) ? data[src2_idx] : '0;

    // head view
    assign head_busy        = busy[head_idx];
    assign head_ready       = ready[head_idx];
    assign head_is_store    = is_store[head_idx];
    assign head_is_branch   = is_branch[head_idx];
    assign head_taken       = taken[head_idx];
    assign head_mispredict  = is_branch[head_idx] && (taken[head_idx] != pred_taken[head_idx]);
    assign head_redirect_pc = taken[head_idx] ? target[head_idx] : fallthrough[head_idx];
    assign head_rd          = rd[head_idx];
    assign head_value       = data[head_idx];
    assign head_pc          = pc[head_idx];

endmodule

// ==== hw/rob_macros.svh ====
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// reorder buffer geometry
`define ROB_DEPTH 8
// slots held back so in-flight dispatches still fit
`define ROB_FULL_MARGIN 2

// datapath and register file
`define XLEN 32
`define NUM_REGS 32

// branch predictor size, indexed by pc[5:2]
`define BHT_ENTRIES 16

`endif

// ==== hw/rob_pkg.sv ====
`include "rob_macros.svh"

package rob_pkg;

    // position inside the circular buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // tag is index plus one
    // zero means the value has no producer in flight
    typedef logic [$clog2(`ROB_DEPTH):0] rob_tag_t;

    // architectural register number
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // data word, pc values use it too
    typedef logic [`XLEN-1:0] word_t;

endpackage

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rdy,
    // dispatch
    input  logic                alloc_valid,
    input  rob_pkg::reg_idx_t   alloc_rd,
    input  logic                alloc_is_branch,
    input  logic                alloc_is_store,
    input  logic                alloc_pred_taken,
    input  rob_pkg::word_t      alloc_pc,
    input  rob_pkg::word_t      alloc_fallthrough_pc,
    output rob_pkg::rob_tag_t   alloc_tag,
    output logic                full,
    // result buses
    input  logic                ex_valid,
    input  rob_pkg::rob_tag_t   ex_tag,
    input  rob_pkg::word_t      ex_result,
    input  rob_pkg::word_t      ex_target,
    input  logic                ex_taken,
    input  logic                ls_valid,
    input  rob_pkg::rob_tag_t   ls_tag,
    input  rob_pkg::word_t      ls_result,
    // commit and redirect
    output logic                commit_valid,
    output rob_pkg::reg_idx_t   commit_rd,
    output rob_pkg::rob_tag_t   commit_tag,
    output rob_pkg::word_t      commit_value,
    output logic                redirect_valid,
    output rob_pkg::word_t      redirect_pc,
    // operand read
    input  rob_pkg::reg_idx_t   rs1,
    input  rob_pkg::reg_idx_t   rs2,
    output rob_pkg::rob_tag_t   src1_tag,
    output rob_pkg::rob_tag_t   src2_tag,
    output logic                src1_ready,
    output logic                src2_ready,
    output rob_pkg::word_t      src1_data,
    output rob_pkg::word_t      src2_data,
    output rob_pkg::word_t      src1_value,
    output rob_pkg::word_t      src2_value,
    // prediction
    input  rob_pkg::word_t      pred_pc,
    output logic                pred_taken
);

    // control to entry file
    logic              alloc_en;
    rob_pkg::rob_idx_t tail_idx;
    logic              retire_en;
    rob_pkg::rob_idx_t head_idx;
    logic              flush;

    // head view
    logic              head_busy;
    logic              head_ready;
    logic              head_is_store;
    logic              head_is_branch;
    logic              head_mispredict;
    rob_pkg::word_t    head_redirect_pc;
    rob_pkg::reg_idx_t head_rd;
    rob_pkg::word_t    head_value;
    rob_pkg::word_t    head_pc;
    logic              head_taken;

    // predictor training
    logic              bht_update;
    rob_pkg::word_t    bht_pc;
    logic              bht_taken;

    rob_ctrl u_ctrl (.*);

    rob_entry_file u_entries (.*);

    rename_reg_file u_rename (.*);

    branch_history_table u_bht (.*);

endmodule

// ==== sim.f ====
+incdir+hw
hw/rob_pkg.sv
hw/rob_ctrl.sv
hw/rob_entry_file.sv
hw/rename_reg_file.sv
hw/branch_history_table.sv
hw/rob_top.sv
dv/rob_tb.sv
